// File: klPkg.sv
package klPkg;

  // Word and address widths
  localparam int WordBits    = 36;
  localparam int PageBits    = 13;
  localparam int OffsetBits  = 9;
  localparam int VpnBits     = 9;
  localparam int VaBits      = VpnBits + OffsetBits;
  localparam int PhysBits    = PageBits + OffsetBits;

  // Implemented core, pages alias modulo 8
  localparam int MemAddrBits = 12;
  localparam int MemWords    = 1 << MemAddrBits;

  // Direct-mapped map cache
  localparam int MapEntries  = 4;
  localparam int MapIdxBits  = $clog2(MapEntries);
  localparam int MapTagBits  = VpnBits - MapIdxBits;

  // Page-table entry layout, PPN sits in the low PageBits
  localparam int PteValidBit    = 35;
  localparam int PteWritableBit = 34;

  typedef logic [PhysBits-1:0] physAddrT;
  typedef logic [WordBits-1:0] wordT;

endpackage

// File: memIf.sv
`timescale 1ns/10ps
interface memIf import klPkg::*; ();

  logic     req;
  logic     we;
  physAddrT addr;
  wordT     wdata;
  logic     ack;
  wordT     rdata;

  // Requester holds req, we, addr, wdata until the ack pulse
  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    input  ack,
    input  rdata
  );

  modport memory (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output ack,
    output rdata
  );

endinterface

// File: pma.sv
`timescale 1ns/10ps
module pma import klPkg::*; (
  input  logic                clock,
  input  logic                rstN,
  input  logic                ebrLoad,
  input  logic                ubrLoad,
  input  logic [PageBits-1:0] baseValue,
  input  logic                userMode,
  input  logic [VpnBits-1:0]  vpn,
  input  logic                clearStart,
  input  logic [PageBits-1:0] clearPage,
  input  logic                ccaStep,
  output physAddrT            ptAddr,
  output physAddrT            ccaAddr,
  output logic                ccaCryOut,
  output logic                baseChanged
);

  logic [PageBits-1:0]   ebr;
  logic [PageBits-1:0]   ubr;
  logic [PageBits-1:0]   baseSel;
  logic [PageBits-1:0]   ccaPage;
  logic [OffsetBits-1:0] ccaOffset;
  logic                  lowOnes;
  logic                  midOnes;
  logic                  highOnes;

  // Base registers
  always_ff @(posedge clock) begin
    if (!rstN) begin
      ebr         <= '0;
      ubr         <= '0;
      baseChanged <= 1'b0;
    end else begin
      if (ebrLoad) begin
        ebr <= baseValue;
      end
      if (ubrLoad) begin
        ubr <= baseValue;
      end
      baseChanged <= ebrLoad | ubrLoad;
    end
  end

  // Page table address is base page with the vpn as word offset
  assign baseSel = userMode ? ubr : ebr;
  assign ptAddr  = {baseSel, vpn};

  // Offset counter split in three slices with look-ahead carries
  assign lowOnes   = &ccaOffset[1:0];
  assign midOnes   = &ccaOffset[5:2];
  assign highOnes  = &ccaOffset[8:6];
  assign ccaCryOut = lowOnes & midOnes & highOnes;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      ccaPage   <= '0;
      ccaOffset <= '0;
    end else if (clearStart) begin
      ccaPage   <= clearPage;
      ccaOffset <= '0;
    end else if (ccaStep) begin
      ccaOffset[1:0] <= ccaOffset[1:0] + 2'd1;
      if (lowOnes) begin
        ccaOffset[5:2] <= ccaOffset[5:2] + 4'd1;
      end
      // Top slice only moves when both lower slices wrap
      if (lowOnes && midOnes) begin
        ccaOffset[8:6] <= ccaOffset[8:6] + 3'd1;
      end
    end
  end

  assign ccaAddr = {ccaPage, ccaOffset};

endmodule

// File: pageMap.sv
`timescale 1ns/10ps
module pageMap import klPkg::*; (
  input  logic               clock,
  input  logic               rstN,
  input  logic               vaValid,
  input  logic [VaBits-1:0]  va,
  input  logic               userMode,
  input  logic               physical,
  input  logic               write,
  input  wordT               wdata,
  output wordT               rdata,
  output logic               done,
  output logic               fault,
  output logic               busy,
  memIf.requester            mem,
  input  physAddrT           ptAddr,
  input  logic               baseChanged,
  output logic [VpnBits-1:0] vpn,
  output logic               refUser
);

  typedef enum logic [1:0] {Idle, Lookup, PtFetch, Access} stateT;

  stateT                 state;
  logic [VaBits-1:0]     refVa;
  logic                  refPhys;
  logic                  refWrite;
  wordT                  refData;
  physAddrT              accAddr;
  logic [MapEntries-1:0] lineValid;
  logic [MapEntries-1:0] lineUser;
  logic [MapEntries-1:0] lineWritable;
  logic [MapTagBits-1:0] lineTag [MapEntries];
  logic [PageBits-1:0]   linePpn [MapEntries];
  logic [MapIdxBits-1:0] idx;
  logic                  hit;
  logic                  pteValid;
  logic                  pteWritable;

  assign vpn  = refVa[VaBits-1:OffsetBits];
  assign idx  = vpn[MapIdxBits-1:0];
  // Exec and user lines never match each other
  assign hit  = lineValid[idx] && (lineUser[idx] == refUser) &&
                (lineTag[idx] == vpn[VpnBits-1:MapIdxBits]);
  assign busy = (state != Idle);

  assign pteValid    = mem.rdata[PteValidBit];
  assign pteWritable = mem.rdata[PteWritableBit];

  assign mem.req   = (state == PtFetch) || (state == Access);
  assign mem.we    = (state == Access) && refWrite;
  assign mem.addr  = (state == PtFetch) ? ptAddr : accAddr;
  assign mem.wdata = refData;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      state     <= Idle;
      done      <= 1'b0;
      fault     <= 1'b0;
      lineValid <= '0;
    end else begin
      done  <= 1'b0;
      fault <= 1'b0;
      case (state)
        Idle: begin
          if (vaValid) begin
            state <= Lookup;
          end
        end
        Lookup: begin
          if (refPhys) begin
            state <= Access;
          end else if (!hit) begin
            state <= PtFetch;
          end else if (refWrite && !lineWritable[idx]) begin
            state <= Idle;
            fault <= 1'b1;
          end else begin
            state <= Access;
          end
        end
        PtFetch: begin
          if (mem.ack) begin
            if (pteValid) begin
              lineValid[idx] <= 1'b1;
            end
            if (!pteValid || (refWrite && !pteWritable)) begin
              state <= Idle;
              fault <= 1'b1;
            end else begin
              state <= Access;
            end
          end
        end
        default: begin
          if (mem.ack) begin
            state <= Idle;
            done  <= 1'b1;
          end
        end
      endcase
      // A base reload flushes the whole cache
      if (baseChanged) begin
        lineValid <= '0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == Idle && vaValid) begin
      refVa    <= va;
      refUser  <= userMode;
      refPhys  <= physical;
      refWrite <= write;
      refData  <= wdata;
    end
    if (state == Lookup) begin
      accAddr <= refPhys ? physAddrT'(refVa) : {linePpn[idx], refVa[OffsetBits-1:0]};
    end
    if (state == PtFetch && mem.ack) begin
      accAddr <= {mem.rdata[PageBits-1:0], refVa[OffsetBits-1:0]};
      if (pteValid) begin
        lineTag[idx]      <= vpn[VpnBits-1:MapIdxBits];
        linePpn[idx]      <= mem.rdata[PageBits-1:0];
        lineUser[idx]     <= refUser;
        lineWritable[idx] <= pteWritable;
      end
    end
    if (state == Access && mem.ack) begin
      rdata <= mem.rdata;
    end
  end

endmodule

// File: pageClear.sv
`timescale 1ns/10ps
module pageClear import klPkg::*; (
  input  logic     clock,
  input  logic     rstN,
  input  logic     clearStart,
  input  physAddrT ccaAddr,
  input  logic     ccaCryOut,
  output logic     clearBusy,
  output logic     clearDone,
  output logic     ccaStep,
  memIf.requester  mem
);

  logic lastWord;

  // One zero write per CCA position
  assign mem.req   = clearBusy;
  assign mem.we    = 1'b1;
  assign mem.addr  = ccaAddr;
  assign mem.wdata = '0;

  // CCA advances on every acked write
  assign ccaStep  = clearBusy & mem.ack;
  assign lastWord = ccaStep & ccaCryOut;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      clearBusy <= 1'b0;
      clearDone <= 1'b0;
    end else begin
      clearDone <= 1'b0;
      if (!clearBusy) begin
        clearBusy <= clearStart;
      end else if (lastWord) begin
        clearBusy <= 1'b0;
        clearDone <= 1'b1;
      end
    end
  end

endmodule

// File: memArbiter.sv
`timescale 1ns/10ps
module memArbiter (
  input  logic    clock,
  input  logic    rstN,
  memIf.memory    mapPort,
  memIf.memory    clearPort,
  memIf.requester memPort
);

  logic locked;
  logic lockClear;
  logic prefClear;
  logic pickClear;
  logic grantMap;
  logic grantClear;

  // Tie goes to whichever side did not win last
  assign pickClear = clearPort.req & (~mapPort.req | prefClear);

  assign grantClear = locked ? lockClear : pickClear;
  assign grantMap   = locked ? ~lockClear : (mapPort.req & ~pickClear);

  assign memPort.req   = (grantMap & mapPort.req) | (grantClear & clearPort.req);
  assign memPort.we    = grantClear ? clearPort.we : mapPort.we;
  assign memPort.addr  = grantClear ? clearPort.addr : mapPort.addr;
  assign memPort.wdata = grantClear ? clearPort.wdata : mapPort.wdata;

  assign mapPort.ack   = grantMap & memPort.ack;
  assign clearPort.ack = grantClear & memPort.ack;

  // Read data goes to both sides, ack qualifies it
  assign mapPort.rdata   = memPort.rdata;
  assign clearPort.rdata = memPort.rdata;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      locked    <= 1'b0;
      lockClear <= 1'b0;
      prefClear <= 1'b0;
    end else if (locked) begin
      if (memPort.ack) begin
        locked <= 1'b0;
      end
    end else if (memPort.req) begin
      locked    <= 1'b1;
      lockClear <= pickClear;
      prefClear <= ~pickClear;
    end
  end

endmodule

// File: coreMemory.sv
`timescale 1ns/10ps
module coreMemory import klPkg::*; (
  input  logic clock,
  input  logic rstN,
  memIf.memory mem
);

  wordT                   store [MemWords];
  logic [MemAddrBits-1:0] index;
  logic                   accept;

  // Upper address bits are not implemented
  assign index  = mem.addr[MemAddrBits-1:0];
  assign accept = mem.req & ~mem.ack;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      mem.ack <= 1'b0;
    end else begin
      mem.ack <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      if (mem.we) begin
        store[index] <= mem.wdata;
      end
      mem.rdata <= store[index];
    end
  end

endmodule

// File: pmaTop.sv
`timescale 1ns/10ps
module pmaTop import klPkg::*; (
  input  logic                clock,
  input  logic                rstN,
  input  logic                vaValid,
  input  logic [VaBits-1:0]   va,
  input  logic                userMode,
  input  logic                physical,
  input  logic                write,
  input  wordT                wdata,
  output wordT                rdata,
  output logic                done,
  output logic                fault,
  output logic                busy,
  input  logic                ebrLoad,
  input  logic                ubrLoad,
  input  logic [PageBits-1:0] baseValue,
  input  logic                clearStart,
  input  logic [PageBits-1:0] clearPage,
  output logic                clearBusy,
  output logic                clearDone
);

  physAddrT           ptAddr;
  physAddrT           ccaAddr;
  logic               ccaCryOut;
  logic               baseChanged;
  logic               ccaStep;
  logic [VpnBits-1:0] vpn;
  logic               refUser;

  memIf mapBus ();
  memIf clearBus ();
  memIf memBus ();

  pma pma0 (
    .clock       (clock),
    .rstN        (rstN),
    .ebrLoad     (ebrLoad),
    .ubrLoad     (ubrLoad),
    .baseValue   (baseValue),
    .userMode    (refUser),
    .vpn         (vpn),
    .clearStart  (clearStart),
    .clearPage   (clearPage),
    .ccaStep     (ccaStep),
    .ptAddr      (ptAddr),
    .ccaAddr     (ccaAddr),
    .ccaCryOut   (ccaCryOut),
    .baseChanged (baseChanged)
  );

  pageMap pageMap0 (
    .clock       (clock),
    .rstN        (rstN),
    .vaValid     (vaValid),
    .va          (va),
    .userMode    (userMode),
    .physical    (physical),
    .write       (write),
    .wdata       (wdata),
    .rdata       (rdata),
    .done        (done),
    .fault       (fault),
    .busy        (busy),
    .mem         (mapBus.requester),
    .ptAddr      (ptAddr),
    .baseChanged (baseChanged),
    .vpn         (vpn),
    .refUser     (refUser)
  );

  pageClear pageClear0 (
    .clock      (clock),
    .rstN       (rstN),
    .clearStart (clearStart),
    .ccaAddr    (ccaAddr),
    .ccaCryOut  (ccaCryOut),
    .clearBusy  (clearBusy),
    .clearDone  (clearDone),
    .ccaStep    (ccaStep),
    .mem        (clearBus.requester)
  );

  memArbiter memArbiter0 (
    .clock     (clock),
    .rstN      (rstN),
    .mapPort   (mapBus.memory),
    .clearPort (clearBus.memory),
    .memPort   (memBus.requester)
  );

  coreMemory coreMemory0 (
    .clock (clock),
    .rstN  (rstN),
    .mem   (memBus.memory)
  );

endmodule

// File: pmaTb_assert.sv
`timescale 1ns/10ps
module protocolChecks import klPkg::*; (
  input logic     clock,
  input logic     rstN,
  input logic     grantMap,
  input logic     grantClear,
  input logic     mapReq,
  input logic     mapAck,
  input physAddrT mapAddr,
  input logic     clearReq,
  input logic     clearAck,
  input physAddrT clearAddr,
  input logic     memReq,
  input logic     memAck,
  input logic     done,
  input logic     fault,
  input logic     busy,
  input logic     clearBusy,
  input logic     clearDone
);

  // A grant stays with its requester through the access it was given for
  grantHeld: assert property (@(posedge clock) disable iff (!rstN)
      memReq && !memAck |=> $stable(grantMap) && $stable(grantClear))
    else $error("Memory grant moved before the ack");

  ackAfterReq: assert property (@(posedge clock) disable iff (!rstN) memAck |-> $past(memReq))
    else $error("Memory ack without a request");

  // Requests hold steady until their ack
  mapHeld: assert property (@(posedge clock) disable iff (!rstN)
      mapReq && !mapAck |=> mapReq && $stable(mapAddr))
    else $error("Mapper request dropped or moved before ack");

  clearHeld: assert property (@(posedge clock) disable iff (!rstN)
      clearReq && !clearAck |=> clearReq && $stable(clearAddr))
    else $error("Clearer request dropped or moved before ack");

  doneOrFault: assert property (@(posedge clock) disable iff (!rstN) !(done && fault))
    else $error("done and fault high together");

  quietReset: assert property (@(posedge clock) $rose(rstN) |->
      !(busy || done || fault || clearBusy || clearDone || mapReq || clearReq))
    else $error("Control outputs active right after reset");

endmodule

bind pmaTop protocolChecks protocolChecks0 (
  .*,
  .grantMap   (memArbiter0.grantMap),
  .grantClear (memArbiter0.grantClear),
  .mapReq     (mapBus.req),
  .mapAck     (mapBus.ack),
  .mapAddr    (mapBus.addr),
  .clearReq   (clearBus.req),
  .clearAck   (clearBus.ack),
  .clearAddr  (clearBus.addr),
  .memReq     (memBus.req),
  .memAck     (memBus.ack)
);

// File: pmaTb.sv
`timescale 1ns/10ps
module pmaTb import klPkg::*; ();

  localparam int CycleLimit = 20000;

  logic                clock = 1'b0;
  logic                rstN = 1'b0;
  logic                vaValid = 1'b0;
  logic [VaBits-1:0]   va = '0;
  logic                userMode = 1'b0;
  logic                physical = 1'b0;
  logic                write = 1'b0;
  wordT                wdata = '0;
  logic                ebrLoad = 1'b0;
  logic                ubrLoad = 1'b0;
  logic [PageBits-1:0] baseValue = '0;
  logic                clearStart = 1'b0;
  logic [PageBits-1:0] clearPage = '0;
  wordT                rdata;
  logic                done;
  logic                fault;
  logic                busy;
  logic                clearBusy;
  logic                clearDone;

  // Shadow of core, same modulo-8 page aliasing
  wordT                   shadow [MemWords];
  logic [MemAddrBits-1:0] expIdx;
  logic                   expFault;
  logic                   expWrite;
  wordT                   expData;
  logic [PageBits-1:0]    ebrVal;
  logic [PageBits-1:0]    ubrVal;
  logic [31:0]            rngState = 32'hd300;
  int                     cycles = 0;
  int                     clearsRun = 0;
  int                     clearPulses = 0;

  pmaTop dut0 (.*);

  always #10 clock = ~clock;

  task automatic failRun(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles == CycleLimit) begin
      failRun($sformatf("Run timed out after %0d cycles", CycleLimit));
    end
  end

  always @(posedge clock) begin
    if (done && expWrite) begin
      shadow[expIdx] <= expData;
    end
    if (clearDone) begin
      clearPulses <= clearPulses + 1;
      for (int i = 0; i < 512; i++) begin
        shadow[{clearPage[2:0], 9'(i)}] <= '0;
      end
    end
  end

  readData: assert property (@(posedge clock) disable iff (!rstN)
      done && !expWrite |-> rdata == shadow[expIdx])
    else failRun($sformatf("Fail %0t: rdata %h, expected %h", $time, rdata, shadow[expIdx]));

  faultMatch: assert property (@(posedge clock) disable iff (!rstN) fault |-> expFault)
    else failRun($sformatf("Fail %0t: unexpected fault on va %h", $time, va));

  doneMatch: assert property (@(posedge clock) disable iff (!rstN) done |-> !expFault)
    else failRun($sformatf("Fail %0t: done on va %h, fault expected", $time, va));

  clearOnce: assert property (@(posedge clock) disable iff (!rstN)
      clearDone |-> clearPulses < clearsRun)
    else failRun($sformatf("Fail %0t: extra clearDone pulse", $time));

  // Busy rises the cycle after an accepted reference and falls with done or fault
  busyRise: assert property (@(posedge clock) disable iff (!rstN) vaValid && !busy |=> busy)
    else failRun($sformatf("Fail %0t: busy low after accepted va %h", $time, va));

  busyFall: assert property (@(posedge clock) disable iff (!rstN)
      (done || fault) == $fell(busy))
    else failRun($sformatf("Fail %0t: busy fell out of step with done or fault", $time));

  clearBusyRise: assert property (@(posedge clock) disable iff (!rstN)
      clearStart && !clearBusy |=> clearBusy)
    else failRun($sformatf("Fail %0t: clearBusy low after clearStart", $time));

  clearBusyFall: assert property (@(posedge clock) disable iff (!rstN)
      clearDone == $fell(clearBusy))
    else failRun($sformatf("Fail %0t: clearBusy fell out of step with clearDone", $time));

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic wordT randWord();
    logic [31:0] hi;
    hi = nextRand();
    return {hi[3:0], nextRand()};
  endfunction

  task automatic nextCycle();
    @(posedge clock);
    #1;
  endtask

  task automatic doRef(input logic user, input logic phys, input logic wr,
                       input logic [VaBits-1:0] addr, input wordT data);
    logic [PageBits-1:0] base;
    wordT                pte;
    base = user ? ubrVal : ebrVal;
    pte = shadow[{base[2:0], addr[17:9]}];
    // Walk the shadow page table for the expected target
    expIdx = phys ? addr[11:0] : {pte[2:0], addr[8:0]};
    expFault = !phys && (!pte[PteValidBit] || (wr && !pte[PteWritableBit]));
    expWrite = wr;
    expData = data;
    vaValid = 1'b1;
    va = addr;
    userMode = user;
    physical = phys;
    write = wr;
    wdata = data;
    nextCycle();
    vaValid = 1'b0;
    do nextCycle(); while (!(done || fault));
    nextCycle();
  endtask

  task automatic loadBase(input logic user, input logic [PageBits-1:0] value);
    baseValue = value;
    ebrLoad = !user;
    ubrLoad = user;
    if (user) begin
      ubrVal = value;
    end else begin
      ebrVal = value;
    end
    nextCycle();
    ebrLoad = 1'b0;
    ubrLoad = 1'b0;
  endtask

  task automatic runClear(input logic [PageBits-1:0] page);
    clearPage = page;
    clearStart = 1'b1;
    clearsRun++;
    nextCycle();
    clearStart = 1'b0;
    do nextCycle(); while (!clearDone);
    nextCycle();
  endtask

  initial begin
    int                    t;
    int                    v;
    int                    k;
    logic [31:0]           r;
    logic [PageBits-1:0]   ebrBase;
    logic [PageBits-1:0]   ubrBase;
    logic [PageBits-1:0]   clrPage;
    logic [PageBits-1:0]   ppnTab [2][5];
    logic [OffsetBits-1:0] offTab [2][5];
    logic [OffsetBits-1:0] fillOff [8];
    repeat (8) @(posedge clock);
    #1 rstN = 1'b1;
    for (k = 0; k < 8; k++) begin
      r = nextRand();
      doRef(1'b0, 1'b1, 1'b1, {9'd0, r[8:0]}, randWord());
      doRef(1'b0, 1'b1, 1'b0, {9'd0, r[8:0]}, '0);
    end
    // Exec table in page 1, user table in page 2, data in pages 3 to 6
    r = nextRand();
    ebrBase = {r[9:0], 3'd1};
    ubrBase = {r[19:10], 3'd2};
    for (t = 0; t < 2; t++) begin
      for (v = 0; v < 5; v++) begin
        r = nextRand();
        ppnTab[t][v] = {r[9:0], 3'(3 + 2 * t + v % 2)};
        offTab[t][v] = r[20:12];
        // Entry 3 read-only, entry 4 invalid
        doRef(1'b0, 1'b1, 1'b1, {(t == 1) ? ubrBase[8:0] : ebrBase[8:0], 9'(v)},
              {v != 4, v != 3, 21'd0, ppnTab[t][v]});
      end
    end
    loadBase(1'b0, ebrBase);
    loadBase(1'b1, ubrBase);
    for (t = 0; t < 2; t++) begin
      for (v = 0; v < 3; v++) begin
        doRef(1'(t), 1'b0, 1'b1, {9'(v), offTab[t][v]}, randWord());
        doRef(1'(t), 1'b0, 1'b0, {9'(v), offTab[t][v]}, '0);
        doRef(1'b0, 1'b1, 1'b0, {6'd0, ppnTab[t][v][2:0], offTab[t][v]}, '0);
      end
    end
    doRef(1'b0, 1'b0, 1'b0, {9'd4, 9'd0}, '0);
    doRef(1'b0, 1'b1, 1'b1, {6'd0, ppnTab[0][3][2:0], offTab[0][3]}, randWord());
    doRef(1'b0, 1'b0, 1'b0, {9'd3, offTab[0][3]}, '0);
    doRef(1'b0, 1'b0, 1'b1, {9'd3, offTab[0][3]}, randWord());
    doRef(1'b0, 1'b1, 1'b0, {6'd0, ppnTab[0][3][2:0], offTab[0][3]}, '0);
    // Bring exec vpn 0 back into the map cache
    doRef(1'b0, 1'b0, 1'b0, {9'd0, offTab[0][0]}, '0);
    // Remap exec vpn 0 while it sits in the map cache
    doRef(1'b0, 1'b1, 1'b1, {ebrBase[8:0], 9'd0}, {2'b11, 21'd0, ppnTab[0][1]});
    loadBase(1'b0, ebrBase);
    doRef(1'b0, 1'b0, 1'b0, {9'd0, offTab[0][1]}, '0);
    r = nextRand();
    clrPage = {r[9:0], 3'd7};
    for (k = 0; k < 8; k++) begin
      r = nextRand();
      fillOff[k] = r[8:0];
      doRef(1'b0, 1'b1, 1'b1, {6'd0, 3'd7, fillOff[k]}, randWord());
    end
    runClear(clrPage);
    for (k = 0; k < 8; k++) begin
      doRef(1'b0, 1'b1, 1'b0, {6'd0, 3'd7, fillOff[k]}, '0);
    end
    doRef(1'b0, 1'b1, 1'b0, {6'd0, 3'd7, 9'h1ff}, '0);
    for (k = 0; k < 4; k++) begin
      doRef(1'b0, 1'b1, 1'b1, {6'd0, 3'd7, fillOff[k]}, randWord());
    end
    // Translated traffic against a running clear
    fork
      runClear(clrPage);
      begin
        for (k = 0; k < 12; k++) begin
          r = nextRand();
          t = int'(r[0]);
          v = int'(r[2:1]) % 3;
          doRef(1'(t), 1'b0, r[3], {9'(v), offTab[t][v]}, randWord());
        end
      end
    join
    for (k = 0; k < 4; k++) begin
      doRef(1'b0, 1'b1, 1'b0, {6'd0, 3'd7, fillOff[k]}, '0);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: files.f
klPkg.sv
memIf.sv
pma.sv
pageMap.sv
pageClear.sv
memArbiter.sv
coreMemory.sv
pmaTop.sv
pmaTb_assert.sv
pmaTb.sv
